// File: list.f
+incdir+verilog
+incdir+sim
verilog/lsu_pkg.sv
verilog/lsu_beat_seq.sv
verilog/lsu_load_gather.sv
verilog/lsu_stride_compact.sv
verilog/lsu_load_result.sv
verilog/vector_lsu.sv
sim/lsu_tb.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --top-module lsu_tb -f list.f -o lsu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/lsu_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^Test OK$"; then
    exit 0
fi
echo "pass line not found"
exit 1

// File: sim/lsu_tb_model.svh
// reference model for the load/store testbench, expected load vectors and memory words
`ifndef LSU_TB_MODEL_SVH
`define LSU_TB_MODEL_SVH

// start-up contents, each word differs by bank and by row
function automatic logic [31:0] fill_word(input int b, input int r);
    return {2'(b), 14'(r), 2'(b), 14'(r)} ^ (32'(r * 4 + b) * 32'h9e3779b1);
endfunction

function automatic int beats_of(input lsu_pkg::lmul_e lmul);
    case (lmul)
        lsu_pkg::LMUL_2: return 2;
        lsu_pkg::LMUL_4: return 4;
        default:         return 1;   // unknown codes act as one beat
    endcase
endfunction

function automatic int elem_bits(input lsu_pkg::lsu_op_e op);
    case (op)
        lsu_pkg::LSU_VLE8, lsu_pkg::LSU_VLSE8, lsu_pkg::LSU_VSE8:    return 8;
        lsu_pkg::LSU_VLE16, lsu_pkg::LSU_VLSE16, lsu_pkg::LSU_VSE16: return 16;
        default:                                                     return 32;
    endcase
endfunction

// word b of beat k in the store vector
function automatic logic [31:0] store_word(input lsu_pkg::vec_t data, input int k, input int b);
    return data[k*`LSU_BEAT_W + b*`LSU_BANK_W +: `LSU_BANK_W];
endfunction

// gather the beats from the banks, then keep every stride-th element
function automatic lsu_pkg::vec_t load_exp(input lsu_pkg::lsu_req_t r);
    lsu_pkg::vec_t         gath;
    lsu_pkg::vec_t         res;
    lsu_pkg::vec_t         mask;
    logic [`LSU_ROW_W-1:0] row;
    int                    ew;
    int                    stride;
    int                    count;
    gath   = '0;
    res    = '0;
    ew     = elem_bits(r.op);
    mask   = (lsu_pkg::vec_t'(1) << ew) - lsu_pkg::vec_t'(1);
    count  = beats_of(r.lmul) * `LSU_BEAT_W / ew;
    stride = 1;   // unit-stride
    if (r.op inside {lsu_pkg::LSU_VLSE8, lsu_pkg::LSU_VLSE16, lsu_pkg::LSU_VLSE32}) begin
        stride = int'(r.stride);
    end
    for (int k = 0; k < beats_of(r.lmul); k++) begin
        row = r.base + `LSU_ROW_W'(k);   // rows wrap at the bank size
        for (int b = 0; b < `LSU_BANKS; b++) begin
            gath[k*`LSU_BEAT_W + b*`LSU_BANK_W +: `LSU_BANK_W] = bank[b][row];
        end
    end
    for (int i = 0; i < `LSU_VEC_W / ew; i++) begin
        if (i * stride < count) begin
            res = res | (((gath >> (i * stride * ew)) & mask) << (i * ew));
        end
    end
    return res;
endfunction

`endif

// File: sim/lsu_tb.sv
// testbench for the vector load/store unit, random requests against a bank memory model
`default_nettype none
`include "lsu_cfg.svh"

module lsu_tb;

    localparam int N_STORE  = 40;
    localparam int N_LOAD   = 40;
    localparam int N_STRIDE = 64;   // one load per stride value
    localparam int N_OPS    = N_STORE + N_LOAD + N_STRIDE + 3;
    localparam int LIMIT    = N_OPS * (4 + 2 + 2) + 40;

    typedef lsu_pkg::vec_t wide_t;

    logic               clk;
    logic               nrst;
    logic               start;
    lsu_pkg::lsu_req_t  req;
    lsu_pkg::bank_req_t mem_req;
    lsu_pkg::beat_t     mem_rdata = '0;
    lsu_pkg::vec_t      load_data;
    logic               load_done;
    logic               store_done;
    logic               busy;

    logic [`LSU_BANK_W-1:0] bank [`LSU_BANKS][1 << `LSU_ROW_W];
    int                     rd_total = 0;
    int                     wr_total = 0;
    int                     ld_total = 0;
    int                     st_total = 0;
    int                     cyc = 0;
    int                     errors;
    int                     checks;
    int                     tests;
    logic [31:0]            rng;

    `include "lsu_tb_model.svh"

    vector_lsu dut_i (
        .clk        (clk),
        .nrst       (nrst),
        .start      (start),
        .req        (req),
        .mem_req    (mem_req),
        .mem_rdata  (mem_rdata),
        .load_data  (load_data),
        .load_done  (load_done),
        .store_done (store_done),
        .busy       (busy)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // four synchronous banks, read data one cycle after the row
    always @(posedge clk) begin
        if (!nrst) begin
            for (int b = 0; b < `LSU_BANKS; b++) begin
                for (int r = 0; r < (1 << `LSU_ROW_W); r++) bank[b][r] = fill_word(b, r);
            end
        end else begin
            for (int b = 0; b < `LSU_BANKS; b++) begin
                if (mem_req.rd) mem_rdata[b*`LSU_BANK_W +: `LSU_BANK_W] <= bank[b][mem_req.row];
                if (mem_req.wr) bank[b][mem_req.row] = mem_req.wdata[b];
            end
        end
        if (mem_req.rd) rd_total <= rd_total + 1;
        if (mem_req.wr) wr_total <= wr_total + 1;
        if (load_done) ld_total <= ld_total + 1;
        if (store_done) st_total <= st_total + 1;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc > LIMIT) begin
            $display("timeout, the run went past %0d cycles", LIMIT);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic lsu_pkg::lsu_req_t make_req(input lsu_pkg::lsu_op_e first, input int stride);
        lsu_pkg::lsu_req_t r;
        r.op     = lsu_pkg::lsu_op_e'(4'(int'(first) + int'(next_rand() % 3)));
        r.lmul   = lsu_pkg::lmul_e'(3'(next_rand() % 4));   // 3 is an unused code
        r.stride = `LSU_STRIDE_W'(stride);
        r.base   = `LSU_ROW_W'(next_rand());
        for (int w = 0; w < `LSU_VEC_W / 32; w++) r.data[w*32 +: 32] = next_rand();
        return r;
    endfunction

    task automatic check(input string name, input wide_t got, input wide_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic report(input string name, input int err0);
        tests++;
        $display("%s: %s, %0d errors", name, (errors == err0) ? "pass" : "fail", errors - err0);
    endtask

    // one operation from start to done, poke restarts it while busy
    task automatic run_op(input lsu_pkg::lsu_req_t r, input bit poke);
        int  cycles;
        int  n;
        int  rd0;
        int  wr0;
        int  ld0;
        int  st0;
        bit  store;
        n     = beats_of(r.lmul);
        store = r.op >= lsu_pkg::LSU_VSE8;
        rd0   = rd_total;
        wr0   = wr_total;
        ld0   = ld_total;
        st0   = st_total;
        req   = r;
        start = 1'b1;
        @(posedge clk);
        #1;
        start  = 1'b0;
        cycles = 1;
        check("busy", wide_t'(busy), wide_t'(1'b1));
        while (!(store ? store_done : load_done) && cycles < 16) begin
            start = poke && cycles == 2;
            @(posedge clk);
            #1;
            cycles++;
        end
        start = 1'b0;
        if (cycles >= 16) begin
            errors++;
            $display("no done pulse within 16 cycles of the start before %0t", $time);
        end else begin
            check("done cycles", wide_t'(cycles), wide_t'(store ? n + 1 : n + 3));
        end
        check("busy at done", wide_t'(busy), '0);
        if (!store) check("load_data", load_data, load_exp(r));
        @(posedge clk);
        #1;
        check("read beats", wide_t'(rd_total - rd0), wide_t'(store ? 0 : n));
        check("write beats", wide_t'(wr_total - wr0), wide_t'(store ? n : 0));
        check("load_done pulses", wide_t'(ld_total - ld0), wide_t'(store ? 0 : 1));
        check("store_done pulses", wide_t'(st_total - st0), wide_t'(store ? 1 : 0));
        for (int k = 0; k < n && store; k++) begin
            for (int b = 0; b < `LSU_BANKS; b++) begin
                check($sformatf("bank%0d row %0h", b, r.base + `LSU_ROW_W'(k)),
                      wide_t'(bank[b][r.base + `LSU_ROW_W'(k)]),
                      wide_t'(store_word(r.data, k, b)));
            end
        end
    endtask

    initial begin
        lsu_pkg::lsu_req_t r;
        int                err0;
        int                acc0;
        nrst   = 1'b0;
        start  = 1'b0;
        req    = '0;
        rng    = 32'h445fe365;
        errors = 0;
        checks = 0;
        tests  = 0;
        repeat (3) @(posedge clk);
        #1;
        nrst = 1'b1;

        err0 = errors;
        check("busy", wide_t'(busy), '0);
        check("load_done", wide_t'(load_done), '0);
        check("store_done", wide_t'(store_done), '0);
        check("mem_req.rd", wide_t'(mem_req.rd), '0);
        check("mem_req.wr", wide_t'(mem_req.wr), '0);
        check("load_data", load_data, '0);
        report("reset state", err0);

        err0 = errors;
        for (int i = 0; i < N_STORE; i++) run_op(make_req(lsu_pkg::LSU_VSE8, 0), 1'b0);
        report("unit-stride stores", err0);

        err0 = errors;
        for (int i = 0; i < N_LOAD; i++) begin
            run_op(make_req(lsu_pkg::LSU_VLE8, int'(next_rand() % 64)), 1'b0);
        end
        report("unit-stride loads", err0);

        err0 = errors;
        for (int i = 0; i < N_STRIDE; i++) run_op(make_req(lsu_pkg::LSU_VLSE8, i), 1'b0);
        report("strided loads", err0);

        err0 = errors;
        r      = make_req(lsu_pkg::LSU_VLE8, 3);
        r.lmul = lsu_pkg::LMUL_4;   // long enough to be busy at the second start
        run_op(r, 1'b1);
        r      = make_req(lsu_pkg::LSU_VSE8, 0);
        r.lmul = lsu_pkg::LMUL_4;
        run_op(r, 1'b1);
        acc0   = rd_total + wr_total + ld_total + st_total;
        req.op = lsu_pkg::LSU_NONE;
        start  = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        repeat (6) @(posedge clk);
        #1;
        check("busy after none", wide_t'(busy), '0);
        check("activity after none", wide_t'(rd_total + wr_total + ld_total + st_total - acc0), '0);
        report("ignored starts", err0);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/lsu_beat_seq.sv
// beat sequencer, accepts a request and issues one bank access per cycle
`default_nettype none
`include "lsu_cfg.svh"

module lsu_beat_seq (
    input  wire logic              clk,
    input  wire logic              nrst,
    input  wire logic              start,
    input  wire lsu_pkg::lsu_req_t req,
    input  wire logic              load_done,
    output lsu_pkg::bank_req_t     mem_req,
    output lsu_pkg::beat_tag_t     tag,
    output lsu_pkg::load_ctl_t     ctl,
    output logic                   busy,
    output logic                   store_done
);

    lsu_pkg::lsu_req_t req_q;     // latched at acceptance
    logic              active;    // beats still being issued
    logic              busy_r;
    logic [1:0]        cnt;       // current beat
    logic              is_load;
    logic              is_store;
    logic              strided;
    lsu_pkg::eew_e     eew;
    logic [2:0]        beats;
    logic              last_beat;
    logic              op_known;
    logic              accept;

    // only real load or store codes start an operation
    assign op_known = req.op inside {[lsu_pkg::LSU_VLE8:lsu_pkg::LSU_VSE32]};
    assign busy     = busy_r && !load_done;
    assign accept   = start && !busy && op_known;

    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        strided  = 1'b0;
        eew      = lsu_pkg::EEW_8;
        case (req_q.op)
            lsu_pkg::LSU_VLE8:   is_load = 1'b1;
            lsu_pkg::LSU_VLE16: begin
                is_load = 1'b1;
                eew     = lsu_pkg::EEW_16;
            end
            lsu_pkg::LSU_VLE32: begin
                is_load = 1'b1;
                eew     = lsu_pkg::EEW_32;
            end
            lsu_pkg::LSU_VLSE8: begin
                is_load = 1'b1;
                strided = 1'b1;
            end
            lsu_pkg::LSU_VLSE16: begin
                is_load = 1'b1;
                strided = 1'b1;
                eew     = lsu_pkg::EEW_16;
            end
            lsu_pkg::LSU_VLSE32: begin
                is_load = 1'b1;
                strided = 1'b1;
                eew     = lsu_pkg::EEW_32;
            end
            lsu_pkg::LSU_VSE8:   is_store = 1'b1;
            lsu_pkg::LSU_VSE16: begin
                is_store = 1'b1;
                eew      = lsu_pkg::EEW_16;
            end
            lsu_pkg::LSU_VSE32: begin
                is_store = 1'b1;
                eew      = lsu_pkg::EEW_32;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (req_q.lmul)
            lsu_pkg::LMUL_2: beats = 3'd2;
            lsu_pkg::LMUL_4: beats = 3'd4;
            default:         beats = 3'd1;
        endcase
    end

    assign last_beat = ({1'b0, cnt} == beats - 3'd1);

    // bank b gets word b of the current beat
    always_comb begin
        mem_req.row   = req_q.base + {{(`LSU_ROW_W-2){1'b0}}, cnt};
        mem_req.wdata = req_q.data[cnt*`LSU_BEAT_W +: `LSU_BEAT_W];
        mem_req.rd    = active && is_load;
        mem_req.wr    = active && is_store;
    end

    assign tag.valid = active && is_load;
    assign tag.idx   = cnt;
    assign tag.last  = last_beat;

    assign ctl.eew    = eew;
    assign ctl.stride = strided ? req_q.stride : `LSU_STRIDE_W'(1);
    assign ctl.beats  = beats;

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            active     <= 1'b0;
            busy_r     <= 1'b0;
            cnt        <= 2'd0;
            store_done <= 1'b0;
        end else begin
            store_done <= active && is_store && last_beat;
            if (accept) begin
                active <= 1'b1;
                busy_r <= 1'b1;
                cnt    <= 2'd0;
            end else if (active) begin
                cnt <= cnt + 2'd1;
                if (last_beat) begin
                    active <= 1'b0;
                    if (is_store) begin
                        busy_r <= 1'b0;   // stores end here
                    end
                end
            end else if (load_done) begin
                busy_r <= 1'b0;           // loads end when the result is out
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/lsu_cfg.svh
// vector load/store unit configuration, widths and counts
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// memory banks, one word each per beat
`define LSU_BANKS     4
`define LSU_BANK_W    32

// row address into each bank
`define LSU_ROW_W     14

// one beat spans all banks
`define LSU_BEAT_W    128

// full register group at LMUL 4
`define LSU_VEC_W     512

// stride is counted in elements
`define LSU_STRIDE_W  6

`endif

// File: verilog/lsu_load_gather.sv
// load gather, lines read beats up with their tags and packs them into a vector
`default_nettype none
`include "lsu_cfg.svh"

module lsu_load_gather (
    input  wire logic               clk,
    input  wire logic               nrst,
    input  wire lsu_pkg::beat_tag_t tag,
    input  wire lsu_pkg::beat_t     rdata,
    output lsu_pkg::vec_t           vec,
    output logic                    gathered
);

    lsu_pkg::beat_tag_t tag_q;   // tag of the beat now on rdata

    // memory returns data one cycle after the row
    always_ff @(posedge clk) begin
        if (!nrst) begin
            tag_q    <= '0;
            gathered <= 1'b0;
        end else begin
            tag_q    <= tag;
            gathered <= tag_q.valid && tag_q.last;
        end
    end

    always_ff @(posedge clk) begin
        if (tag_q.valid) begin
            if (tag_q.idx == 2'd0) begin
                // first beat, upper slots read as zero
                vec <= {{(`LSU_VEC_W-`LSU_BEAT_W){1'b0}}, rdata};
            end else begin
                vec[tag_q.idx*`LSU_BEAT_W +: `LSU_BEAT_W] <= rdata;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/lsu_load_result.sv
// load result stage, compacts by element width and registers the load vector
`default_nettype none

module lsu_load_result (
    input  wire logic               clk,
    input  wire logic               nrst,
    input  wire lsu_pkg::vec_t      vec,
    input  wire logic               gathered,
    input  wire lsu_pkg::load_ctl_t ctl,
    output lsu_pkg::vec_t           load_data,
    output logic                    load_done
);

    logic [7:0]    count;     // elements loaded at the selected width
    lsu_pkg::vec_t vec_e8;
    lsu_pkg::vec_t vec_e16;
    lsu_pkg::vec_t vec_e32;
    lsu_pkg::vec_t vec_sel;

    always_comb begin
        case (ctl.eew)
            lsu_pkg::EEW_16: count = 8'(ctl.beats) << 3;
            lsu_pkg::EEW_32: count = 8'(ctl.beats) << 2;
            default:         count = 8'(ctl.beats) << 4;
        endcase
    end

    lsu_stride_compact #(.elem_t(logic [7:0])) u_compact_e8 (
        .vec        (vec),
        .stride     (ctl.stride),
        .count      (count),
        .packed_vec (vec_e8)
    );

    lsu_stride_compact #(.elem_t(logic [15:0])) u_compact_e16 (
        .vec        (vec),
        .stride     (ctl.stride),
        .count      (count),
        .packed_vec (vec_e16)
    );

    lsu_stride_compact #(.elem_t(logic [31:0])) u_compact_e32 (
        .vec        (vec),
        .stride     (ctl.stride),
        .count      (count),
        .packed_vec (vec_e32)
    );

    always_comb begin
        case (ctl.eew)
            lsu_pkg::EEW_16: vec_sel = vec_e16;
            lsu_pkg::EEW_32: vec_sel = vec_e32;
            default:         vec_sel = vec_e8;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            load_data <= '0;
            load_done <= 1'b0;
        end else begin
            load_done <= gathered;
            if (gathered) begin
                load_data <= vec_sel;   // held until the next load
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/lsu_pkg.sv
// shared opcode encodings and bus structs of the vector load/store unit
`default_nettype none
`include "lsu_cfg.svh"

package lsu_pkg;

    typedef enum logic [3:0] {
        LSU_NONE   = 4'd0,
        LSU_VLE8   = 4'd1,
        LSU_VLE16  = 4'd2,
        LSU_VLE32  = 4'd3,
        LSU_VLSE8  = 4'd4,
        LSU_VLSE16 = 4'd5,
        LSU_VLSE32 = 4'd6,
        LSU_VSE8   = 4'd7,
        LSU_VSE16  = 4'd8,
        LSU_VSE32  = 4'd9
    } lsu_op_e;

    // codes outside this set fall back to one beat
    typedef enum logic [2:0] {
        LMUL_1 = 3'd0,
        LMUL_2 = 3'd1,
        LMUL_4 = 3'd2
    } lmul_e;

    typedef enum logic [1:0] {
        EEW_8,
        EEW_16,
        EEW_32
    } eew_e;

    typedef logic [`LSU_BEAT_W-1:0] beat_t;
    typedef logic [`LSU_VEC_W-1:0]  vec_t;

    typedef struct packed {
        lsu_op_e                  op;
        lmul_e                    lmul;
        logic [`LSU_STRIDE_W-1:0] stride;
        logic [`LSU_ROW_W-1:0]    base;    // first bank row
        vec_t                     data;    // store source
    } lsu_req_t;

    typedef struct packed {
        logic [`LSU_ROW_W-1:0]                   row;
        logic [`LSU_BANKS-1:0][`LSU_BANK_W-1:0]  wdata;
        logic                                    rd;
        logic                                    wr;
    } bank_req_t;

    typedef struct packed {
        logic       valid;
        logic [1:0] idx;     // beat slot in the vector
        logic       last;
    } beat_tag_t;

    typedef struct packed {
        eew_e                     eew;
        logic [`LSU_STRIDE_W-1:0] stride;  // 1 for unit-stride loads
        logic [2:0]               beats;
    } load_ctl_t;

endpackage

`default_nettype wire

// File: verilog/lsu_stride_compact.sv
// stride compaction, moves every stride-th element to the bottom of the vector
`default_nettype none
`include "lsu_cfg.svh"

module lsu_stride_compact #(
    parameter type elem_t = logic [7:0]
) (
    input  wire lsu_pkg::vec_t            vec,
    input  wire logic [`LSU_STRIDE_W-1:0] stride,
    input  wire logic [7:0]               count,
    output lsu_pkg::vec_t                 packed_vec
);

    localparam int ELEM_W = $bits(elem_t);
    localparam int N_ELEM = `LSU_VEC_W / ELEM_W;

    elem_t [N_ELEM-1:0] in_e;
    elem_t [N_ELEM-1:0] out_e;

    assign in_e       = vec;
    assign packed_vec = out_e;

    always_comb begin
        int unsigned src;
        for (int i = 0; i < N_ELEM; i++) begin
            src = i * stride;
            // elements past the loaded count stay zero
            if (src < 32'(count)) begin
                out_e[i] = in_e[src];
            end else begin
                out_e[i] = '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/vector_lsu.sv
// vector load/store unit top, between a vector register and four memory banks
`default_nettype none

module vector_lsu (
    input  wire logic              clk,
    input  wire logic              nrst,
    input  wire logic              start,
    input  wire lsu_pkg::lsu_req_t req,
    output lsu_pkg::bank_req_t     mem_req,
    input  wire lsu_pkg::beat_t    mem_rdata,
    output lsu_pkg::vec_t          load_data,
    output logic                   load_done,
    output logic                   store_done,
    output logic                   busy
);

    lsu_pkg::beat_tag_t tag;
    lsu_pkg::load_ctl_t ctl;
    lsu_pkg::vec_t      gather_vec;
    logic               gathered;

    lsu_beat_seq u_seq (
        .clk        (clk),
        .nrst       (nrst),
        .start      (start),
        .req        (req),
        .load_done  (load_done),   // closes a load and drops busy
        .mem_req    (mem_req),
        .tag        (tag),
        .ctl        (ctl),
        .busy       (busy),
        .store_done (store_done)
    );

    lsu_load_gather u_gather (
        .clk      (clk),
        .nrst     (nrst),
        .tag      (tag),
        .rdata    (mem_rdata),
        .vec      (gather_vec),
        .gathered (gathered)
    );

    lsu_load_result u_result (
        .clk       (clk),
        .nrst      (nrst),
        .vec       (gather_vec),
        .gathered  (gathered),
        .ctl       (ctl),
        .load_data (load_data),
        .load_done (load_done)
    );

endmodule

`default_nettype wire
